//--- include/cpu_config.svh
// Core widths and reset values; include wherever the RTL or testbench needs them
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Integer register and data path width
`define CPU_XLEN 64

// Architectural register count, x0 included
`define CPU_NREGS 32

// Program counter value after reset
`define CPU_RESET_PC 64'h0000_0000_0000_0000

// ADDI x0,x0,0
// Loaded into the instruction register on reset and on every flush
`define CPU_NOP 32'h0000_0013

`endif

//--- source/cpu_pkg.sv
// Shared core types: opcodes, ALU ops, operand selects and the instruction word union
package cpu_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;  // Operand A source
    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} b_sel_e; // Operand B source

    // funct3 codes of the decoded subset
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_DOUBLE  = 3'b011; // LD and SD
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd;  opcode_e    opcode;
    } r_fmt_t;
    typedef struct packed {
        logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0]  rd;  opcode_e    opcode;
    } i_fmt_t;
    typedef struct packed {
        logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3;   logic [4:0] imm_4_0; opcode_e opcode;
    } s_fmt_t;
    typedef struct packed {
        logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; opcode_e opcode;
    } b_fmt_t;
    typedef struct packed {
        logic [19:0] imm_31_12; logic [4:0] rd; opcode_e opcode;
    } u_fmt_t;
    typedef struct packed {
        logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
        logic [4:0] rd; opcode_e opcode;
    } j_fmt_t;

    // One 32-bit word, viewed through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

//--- source/cpu_fetch.sv
// Fetch stage: PC, instruction register and redirect flush; instantiated once in cpu_core
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_fetch (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    input  logic [31:0]          imem_data, // Word at imem_addr, same cycle
    input  logic                 redirect,  // Taken branch or JAL in execute
    input  logic [`CPU_XLEN-1:0] imm,       // Offset of the executing instruction
    output logic [`CPU_XLEN-1:0] imem_addr,
    output cpu_pkg::instr_u      ir,
    output logic [`CPU_XLEN-1:0] ir_pc      // PC of the word held in ir
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_plus4; // Sequential next PC
    logic [`CPU_XLEN-1:0] target;   // Branch or jump destination

    assign imem_addr = pc;  // Combinational instruction address
    assign pc_plus4  = pc + `CPU_XLEN'd4;
    assign target    = ir_pc + imm; // Relative to the executing instruction

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc    <= `CPU_RESET_PC;
            ir    <= `CPU_NOP;
            ir_pc <= `CPU_RESET_PC;
        end else if (redirect) begin
            // Word fetched this cycle is on the wrong path
            pc    <= target;
            ir    <= `CPU_NOP; // One bubble
            ir_pc <= pc;
        end else begin
            pc    <= pc_plus4;
            ir    <= imem_data;
            ir_pc <= pc;
        end
    end

    // Redirect targets come from imm_gen, so a bad offset shows up here
    a_pc_aligned: assert property (
        @(posedge clk_1hz) disable iff (!reset_n) pc[1:0] == 2'b00
    ) else $error("fetch PC not word aligned: %h", pc);

endmodule

//--- source/cpu_control.sv
// Execute-stage decoder: turns the instruction register into datapath and strobe controls
`timescale 1ns/100ps

module cpu_control (
    input  cpu_pkg::instr_u ir,
    input  logic            zero,     // ALU result is zero
    output cpu_pkg::a_sel_e a_sel,
    output cpu_pkg::b_sel_e b_sel,
    output cpu_pkg::alu_op_e alu_op,
    output logic            reg_we,   // Register write at end of cycle
    output logic            wb_load,  // Write back load data instead of ALU
    output logic            dmem_we,  // Store strobe
    output logic            redirect  // Load branch target, flush fetch
);

    always_comb begin
        // Defaults describe a no-operation
        a_sel    = cpu_pkg::A_RS1;
        b_sel    = cpu_pkg::B_IMM;
        alu_op   = cpu_pkg::ALU_ADD;
        reg_we   = 1'b0;
        wb_load  = 1'b0;
        dmem_we  = 1'b0;
        redirect = 1'b0;

        case (ir.r_fmt.opcode)
            cpu_pkg::OPC_LUI: begin
                a_sel  = cpu_pkg::A_ZERO; // 0 + imm
                reg_we = 1'b1;
            end
            cpu_pkg::OPC_AUIPC: begin
                a_sel  = cpu_pkg::A_PC;   // pc + imm
                reg_we = 1'b1;
            end
            cpu_pkg::OPC_OP_IMM: begin
                reg_we = 1'b1;
                case (ir.i_fmt.funct3)
                    cpu_pkg::F3_ADD_SUB: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::F3_XOR:     alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::F3_OR:      alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::F3_AND:     alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::F3_SLL:     alu_op = cpu_pkg::ALU_SLL;
                    cpu_pkg::F3_SRL_SRA: begin
                        // Bit 30 picks arithmetic shift
                        alu_op = ir.r_fmt.funct7[5] ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
                    end
                    default: reg_we = 1'b0; // SLTI, SLTIU not supported
                endcase
            end
            cpu_pkg::OPC_OP: begin
                b_sel  = cpu_pkg::B_RS2;
                reg_we = 1'b1;
                case (ir.r_fmt.funct3)
                    cpu_pkg::F3_ADD_SUB: begin
                        alu_op = ir.r_fmt.funct7[5] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    end
                    cpu_pkg::F3_XOR: alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::F3_OR:  alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::F3_AND: alu_op = cpu_pkg::ALU_AND;
                    default:         reg_we = 1'b0; // Register shifts, compares
                endcase
            end
            cpu_pkg::OPC_LOAD: begin
                if (ir.i_fmt.funct3 == cpu_pkg::F3_DOUBLE) begin // LD only
                    reg_we  = 1'b1;
                    wb_load = 1'b1;  // Address is rs1 + imm
                end
            end
            cpu_pkg::OPC_STORE: begin
                if (ir.r_fmt.funct3 == cpu_pkg::F3_DOUBLE) begin // SD only
                    dmem_we = 1'b1;
                end
            end
            cpu_pkg::OPC_BRANCH: begin
                // Compare by subtraction so zero means equal
                b_sel  = cpu_pkg::B_RS2;
                alu_op = cpu_pkg::ALU_SUB;
                case (ir.r_fmt.funct3)
                    cpu_pkg::F3_BEQ: redirect = zero;
                    cpu_pkg::F3_BNE: redirect = !zero;
                    default:         redirect = 1'b0; // Ordered compares dropped
                endcase
            end
            cpu_pkg::OPC_JAL: begin
                a_sel    = cpu_pkg::A_PC;   // Link is pc + 4
                b_sel    = cpu_pkg::B_FOUR;
                reg_we   = 1'b1;
                redirect = 1'b1;
            end
            default: begin
                // Unknown opcode, every strobe stays low
            end
        endcase
    end

endmodule

//--- source/cpu_imm_gen.sv
// Immediate generator: sign-extends the immediate of the instruction in execute
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_imm_gen (
    input  cpu_pkg::instr_u      ir,
    output logic [`CPU_XLEN-1:0] imm
);

    logic is_shift; // SLLI, SRLI, SRAI

    assign is_shift = (ir.i_fmt.funct3 == cpu_pkg::F3_SLL) ||
                      (ir.i_fmt.funct3 == cpu_pkg::F3_SRL_SRA);

    always_comb begin
        case (ir.r_fmt.opcode)
            cpu_pkg::OPC_OP_IMM: begin
                if (is_shift) imm = {{(`CPU_XLEN-6){1'b0}}, ir.i_fmt.imm[5:0]}; // shamt
                else          imm = {{(`CPU_XLEN-12){ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
            end
            cpu_pkg::OPC_LOAD:   imm = {{(`CPU_XLEN-12){ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
            cpu_pkg::OPC_STORE:  imm = {{(`CPU_XLEN-12){ir.s_fmt.imm_11_5[6]}},
                                        ir.s_fmt.imm_11_5, ir.s_fmt.imm_4_0};
            cpu_pkg::OPC_BRANCH: imm = {{(`CPU_XLEN-13){ir.b_fmt.imm_12}}, ir.b_fmt.imm_12,
                                        ir.b_fmt.imm_11, ir.b_fmt.imm_10_5,
                                        ir.b_fmt.imm_4_1, 1'b0}; // Halfword offset
            cpu_pkg::OPC_LUI,
            cpu_pkg::OPC_AUIPC:  imm = {{(`CPU_XLEN-32){ir.u_fmt.imm_31_12[19]}},
                                        ir.u_fmt.imm_31_12, 12'b0};
            cpu_pkg::OPC_JAL:    imm = {{(`CPU_XLEN-21){ir.j_fmt.imm_20}}, ir.j_fmt.imm_20,
                                        ir.j_fmt.imm_19_12, ir.j_fmt.imm_11,
                                        ir.j_fmt.imm_10_1, 1'b0};
            default:             imm = '0; // R format and unknown words
        endcase
    end

endmodule

//--- source/cpu_regfile.sv
// Integer register file with write-back select; x0 reads as zero
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_regfile (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    input  cpu_pkg::instr_u      ir,         // Source of rs1, rs2 and rd
    input  logic                 reg_we,
    input  logic                 wb_load,    // Select load data for write-back
    input  logic [`CPU_XLEN-1:0] alu_result,
    input  logic [`CPU_XLEN-1:0] dmem_rdata,
    output logic [`CPU_XLEN-1:0] rs1_data,
    output logic [`CPU_XLEN-1:0] rs2_data
);

    localparam int REG_AW = $clog2(`CPU_NREGS);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
    logic [REG_AW-1:0]    rs1_idx;
    logic [REG_AW-1:0]    rs2_idx;
    logic [REG_AW-1:0]    rd_idx;
    logic [`CPU_XLEN-1:0] wb_data;

    assign rs1_idx  = ir.r_fmt.rs1;
    assign rs2_idx  = ir.r_fmt.rs2;
    assign rd_idx   = ir.r_fmt.rd;
    assign wb_data  = wb_load ? dmem_rdata : alu_result;
    assign rs1_data = regs[rs1_idx]; // Asynchronous reads
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) regs[i] <= '0;
        end else if (reg_we && (rd_idx != '0)) begin // x0 writes dropped
            regs[rd_idx] <= wb_data;
        end
    end

    // Either read port addressing x0 returns zero
    a_x0_zero: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0)
    ) else $error("x0 read back nonzero");

endmodule

//--- source/cpu_alu.sv
// Execute-stage ALU: operand muxes, 64-bit operations and the zero flag for branches
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_alu (
    input  logic [`CPU_XLEN-1:0] rs1_data,
    input  logic [`CPU_XLEN-1:0] rs2_data,
    input  logic [`CPU_XLEN-1:0] ir_pc,
    input  logic [`CPU_XLEN-1:0] imm,
    input  cpu_pkg::a_sel_e      a_sel,
    input  cpu_pkg::b_sel_e      b_sel,
    input  cpu_pkg::alu_op_e     alu_op,
    output logic [`CPU_XLEN-1:0] result, // Also the data memory address
    output logic                 zero
);

    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] op_b;
    logic [5:0]           shamt; // RV64 shift amount

    always_comb begin
        case (a_sel)
            cpu_pkg::A_RS1: op_a = rs1_data;
            cpu_pkg::A_PC:  op_a = ir_pc;  // AUIPC, JAL link
            default:        op_a = '0;     // LUI
        endcase
        case (b_sel)
            cpu_pkg::B_RS2:  op_b = rs2_data;
            cpu_pkg::B_IMM:  op_b = imm;
            cpu_pkg::B_FOUR: op_b = `CPU_XLEN'd4;
            default:         op_b = '0;
        endcase
    end

    assign shamt = op_b[5:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: result = op_a + op_b;
            cpu_pkg::ALU_SUB: result = op_a - op_b; // Branch compare
            cpu_pkg::ALU_XOR: result = op_a ^ op_b;
            cpu_pkg::ALU_OR:  result = op_a | op_b;
            cpu_pkg::ALU_AND: result = op_a & op_b;
            cpu_pkg::ALU_SLL: result = op_a << shamt;
            cpu_pkg::ALU_SRL: result = op_a >> shamt;
            default:          result = $unsigned($signed(op_a) >>> shamt); // SRA
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- source/cpu_core.sv
// Two-stage RV64 integer core top level; connects fetch, decode, immediates, registers and ALU
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_core (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    input  logic [31:0]          imem_data,  // Instruction memory, combinational
    input  logic [`CPU_XLEN-1:0] dmem_rdata, // Data memory, combinational
    output logic [`CPU_XLEN-1:0] imem_addr,
    output logic [`CPU_XLEN-1:0] dmem_addr,
    output logic [`CPU_XLEN-1:0] dmem_wdata,
    output logic                 dmem_we
);

    cpu_pkg::instr_u      ir;
    logic [`CPU_XLEN-1:0] ir_pc;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] rs1_data;
    logic [`CPU_XLEN-1:0] rs2_data;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 zero;
    cpu_pkg::a_sel_e      a_sel;
    cpu_pkg::b_sel_e      b_sel;
    cpu_pkg::alu_op_e     alu_op;
    logic                 reg_we;
    logic                 wb_load;
    logic                 redirect;

    assign dmem_addr  = alu_result; // rs1 + imm for LD and SD
    assign dmem_wdata = rs2_data;

    cpu_fetch u_cpu_fetch (
        .clk_1hz   (clk_1hz),
        .reset_n   (reset_n),
        .imem_data (imem_data),
        .redirect  (redirect),
        .imm       (imm),
        .imem_addr (imem_addr),
        .ir        (ir),
        .ir_pc     (ir_pc)
    );

    cpu_control u_cpu_control (
        .ir       (ir),
        .zero     (zero),
        .a_sel    (a_sel),
        .b_sel    (b_sel),
        .alu_op   (alu_op),
        .reg_we   (reg_we),
        .wb_load  (wb_load),
        .dmem_we  (dmem_we),
        .redirect (redirect)
    );

    cpu_imm_gen u_cpu_imm_gen (
        .ir  (ir),
        .imm (imm)
    );

    cpu_regfile u_cpu_regfile (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .ir         (ir),
        .reg_we     (reg_we),
        .wb_load    (wb_load),
        .alu_result (alu_result),
        .dmem_rdata (dmem_rdata),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    cpu_alu u_cpu_alu (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ir_pc    (ir_pc),
        .imm      (imm),
        .a_sel    (a_sel),
        .b_sel    (b_sel),
        .alu_op   (alu_op),
        .result   (alu_result),
        .zero     (zero)
    );

    // Flushed slot after a redirect neither stores nor redirects
    a_redirect_flush: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        redirect |=> (!redirect && !dmem_we)
    ) else $error("store or redirect leaked past a flush");

endmodule

//--- tests/tb_cpu.sv
// Testbench for cpu_core: builds a program, models memories and checks every store by assertion
`timescale 1ns/100ps
`include "cpu_config.svh"

module tb_cpu;

    logic        clk_1hz;
    logic        reset_n;
    logic [31:0] imem_data;
    logic [63:0] dmem_rdata;
    logic [63:0] imem_addr;
    logic [63:0] dmem_addr;
    logic [63:0] dmem_wdata;
    logic        dmem_we;

    logic [31:0] imem [256];         // Instruction memory, word indexed
    logic [63:0] dmem [256];         // Data memory, doubleword indexed
    logic [63:0] m    [32];          // Architectural register model
    logic [63:0] exp_addr [64];
    logic [63:0] exp_data [64];
    int          n_exp;
    int          st_idx;
    int          pc_w;
    int          slot;
    int          err_cnt;
    int          cur_test;
    int          tend [6];
    int          terr [6];
    string       tname [6];
    logic [63:0] beq_pc = 64'hFFFF_0000; // Far away until the program is built
    logic [63:0] jal_pc = 64'hFFFF_1000;
    logic [15:0] lfsr = 16'd51;
    bit          built;

    cpu_core u_cpu_core (
        .clk_1hz(clk_1hz), .reset_n(reset_n), .imem_data(imem_data),
        .dmem_rdata(dmem_rdata), .imem_addr(imem_addr), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_we(dmem_we)
    );

    assign imem_data  = imem[imem_addr[9:2]];  // Answer within the cycle
    assign dmem_rdata = dmem[dmem_addr[10:3]];

    always @(posedge clk_1hz) begin
        if (dmem_we) dmem[dmem_addr[10:3]] <= dmem_wdata;
        if (reset_n && dmem_we) st_idx <= st_idx + 1; // Next expected store
    end

    initial begin
        clk_1hz = 1'b0;
        forever #2 clk_1hz = ~clk_1hz;
    end

    task automatic note_fail();
        err_cnt++;
        terr[cur_test]++;
    endtask

    // Instruction encoders
    function automatic logic [31:0] enc_i(cpu_pkg::opcode_e opc, logic [4:0] rd,
                                          logic [2:0] f3, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
    endfunction
    function automatic logic [31:0] enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], cpu_pkg::OPC_STORE};
    endfunction
    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::OPC_BRANCH};
    endfunction
    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::OPC_JAL};
    endfunction

    function automatic logic [63:0] sx12(logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    task automatic put(logic [31:0] word);
        imem[pc_w] = word;
        pc_w++;
    endtask

    task automatic wr(logic [4:0] rd, logic [63:0] val);
        if (rd != 5'd0) m[rd] = val; // x0 stays zero
    endtask

    // Immediate ops, modeled from the ISA rules
    task automatic do_opi(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        logic [63:0] a;
        logic [63:0] r;
        a = m[rs1];
        case (f3)
            3'b100:  r = a ^ sx12(imm);
            3'b110:  r = a | sx12(imm);
            3'b111:  r = a & sx12(imm);
            3'b001:  r = a << imm[5:0];
            3'b101:  r = imm[10] ? 64'($signed(a) >>> imm[5:0]) : a >> imm[5:0];
            default: r = a + sx12(imm);
        endcase
        put(enc_i(cpu_pkg::OPC_OP_IMM, rd, f3, rs1, imm));
        wr(rd, r);
    endtask

    task automatic do_op(bit sub, logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                         logic [4:0] rs2);
        logic [63:0] r;
        case (f3)
            3'b100:  r = m[rs1] ^ m[rs2];
            3'b110:  r = m[rs1] | m[rs2];
            3'b111:  r = m[rs1] & m[rs2];
            default: r = sub ? m[rs1] - m[rs2] : m[rs1] + m[rs2];
        endcase
        put(enc_r(sub ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd));
        wr(rd, r);
    endtask

    // SD rs2 to the next free slot above the x1 base
    task automatic do_sd(logic [4:0] rs2);
        logic [11:0] off;
        off = 12'(slot * 8);
        put(enc_s(rs2, 5'd1, off));
        exp_addr[n_exp] = m[1] + sx12(off);
        exp_data[n_exp] = m[rs2];
        n_exp++;
        slot++;
    endtask

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [11:0] rand_bits(int n);
        logic        fb;
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[10:0], fb};
        end
        return v;
    endfunction

    task automatic build_program();
        logic [11:0] r;
        logic [11:0] k;
        logic [19:0] u;
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(cpu_pkg::OPC_OP_IMM, 5'd0, 3'b000, 5'd0, 12'(i)); // NOP fill
            dmem[i] = {16'hDA7A, 40'h0, 8'(i)};
        end
        for (int i = 0; i < 32; i++) m[i] = '0;
        // Arithmetic and logic
        do_opi(3'b000, 5'd1, 5'd0, 12'd256);   // Store base
        do_opi(3'b000, 5'd2, 5'd0, 12'h5A3);
        do_opi(3'b000, 5'd3, 5'd0, 12'hD44);   // -700
        do_opi(3'b000, 5'd5, 5'd2, 12'hFFD);
        do_sd(5);
        do_op(0, 3'b000, 5'd5, 5'd2, 5'd3);
        do_sd(5);
        do_op(1, 3'b000, 5'd5, 5'd2, 5'd3);
        do_sd(5);
        do_op(0, 3'b100, 5'd5, 5'd3, 5'd2);
        do_sd(5);
        do_op(0, 3'b110, 5'd5, 5'd3, 5'd2);
        do_sd(5);
        do_op(0, 3'b111, 5'd5, 5'd3, 5'd2);
        do_sd(5);
        do_opi(3'b001, 5'd5, 5'd3, 12'd37);
        do_sd(5);
        do_opi(3'b101, 5'd5, 5'd3, 12'd5);
        do_sd(5);
        do_opi(3'b101, 5'd5, 5'd3, 12'h43C);  // SRAI by 60
        do_sd(5);
        tend[1] = n_exp;
        // Upper immediates, LUI with bit 31 set
        u = 20'h80012;
        put({u, 5'd6, cpu_pkg::OPC_LUI});
        wr(5'd6, {{32{u[19]}}, u, 12'h0});
        do_sd(6);
        u = 20'h12345;
        wr(5'd7, 64'(pc_w * 4) + {32'h0, u, 12'h0});
        put({u, 5'd7, cpu_pkg::OPC_AUIPC});
        do_sd(7);
        tend[2] = n_exp;
        // Load and store round trip
        k = 12'(slot * 8);
        do_sd(2);
        put(enc_i(cpu_pkg::OPC_LOAD, 5'd8, 3'b011, 5'd1, k));
        wr(5'd8, m[2]);
        do_sd(8);
        tend[3] = n_exp;
        // Control flow, markers go to base minus 8 and must never land
        do_opi(3'b000, 5'd9, 5'd0, 12'd5);
        do_opi(3'b000, 5'd10, 5'd0, 12'd5);
        beq_pc = 64'(pc_w * 4);
        put(enc_b(3'b000, 5'd9, 5'd10, 13'd12)); // Target lies past two markers
        put(enc_s(5'd9, 5'd1, 12'hFF8));
        put(enc_s(5'd9, 5'd1, 12'hFF8));
        put(enc_b(3'b001, 5'd9, 5'd10, 13'd8)); // Equal, falls through
        do_sd(9);
        jal_pc = 64'(pc_w * 4);
        put(enc_j(5'd11, 21'd12));
        wr(5'd11, jal_pc + 64'd4);
        put(enc_s(5'd9, 5'd1, 12'hFF8));
        put(enc_s(5'd9, 5'd1, 12'hFF8));
        do_sd(11);
        tend[4] = n_exp;
        // Random immediates on a chain
        do_op(0, 3'b000, 5'd12, 5'd2, 5'd0);
        for (int i = 0; i < 8; i++) begin
            k = rand_bits(2);
            r = rand_bits(12);
            case (k[1:0])
                2'd0:    do_opi(3'b000, 5'd12, 5'd12, r);
                2'd1:    do_opi(3'b100, 5'd12, 5'd12, r);
                default: do_opi(3'b111, 5'd12, 5'd12, r);
            endcase
            do_sd(12);
        end
        tend[5] = n_exp;
        put(enc_j(5'd0, 21'd0)); // Park in a self loop
        built = 1'b1;
    endtask

    a_store_count: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        dmem_we |-> st_idx < n_exp)
    else begin
        $display("Store beyond the expected list, address %h", $sampled(dmem_addr));
        note_fail();
    end

    a_store_addr: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (dmem_we && st_idx < n_exp) |-> dmem_addr == exp_addr[st_idx])
    else begin
        $display("Fail %0t dmem_addr exp %h got %h", $time,
                 exp_addr[$sampled(st_idx)], $sampled(dmem_addr));
        note_fail();
    end

    a_store_data: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (dmem_we && st_idx < n_exp) |-> dmem_wdata == exp_data[st_idx])
    else begin
        $display("Fail %0t dmem_wdata exp %h got %h", $time,
                 exp_data[$sampled(st_idx)], $sampled(dmem_wdata));
        note_fail();
    end

    // Target shows one cycle after the branch executes
    a_beq_target: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        imem_addr == beq_pc + 64'd4 |=> imem_addr == beq_pc + 64'd12)
    else begin
        $display("Fail %0t imem_addr exp %h got %h", $time, beq_pc + 64'd12,
                 $sampled(imem_addr));
        note_fail();
    end

    a_jal_target: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        imem_addr == jal_pc + 64'd4 |=> imem_addr == jal_pc + 64'd12)
    else begin
        $display("Fail %0t imem_addr exp %h got %h", $time, jal_pc + 64'd12,
                 $sampled(imem_addr));
        note_fail();
    end

    task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
        assert (got === exp) else begin
            $display("Fail %0t %s exp %h got %h", $time, name, exp, got);
            note_fail();
        end
    endtask

    initial begin
        wait (built);
        #(pc_w * 16 + 400); // Four cycles per instruction plus margin
        $display("Timeout, the program did not finish its stores");
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset_n  = 1'b0;
        st_idx   = 0;
        n_exp    = 0;
        pc_w     = 0;
        slot     = 0;
        err_cnt  = 0;
        cur_test = 0;
        tname    = '{"reset", "alu", "upper_imm", "load_store", "control_flow", "random"};
        foreach (terr[i]) terr[i] = 0;
        build_program();
        repeat (3) begin
            @(negedge clk_1hz);
            check_val("imem_addr", `CPU_RESET_PC, imem_addr);
            check_val("dmem_we", 64'd0, 64'(dmem_we));
        end
        reset_n = 1'b1;                 // Release on the falling edge
        #1;
        check_val("imem_addr", `CPU_RESET_PC, imem_addr);
        check_val("dmem_we", 64'd0, 64'(dmem_we));
        @(negedge clk_1hz);
        check_val("imem_addr", `CPU_RESET_PC + 64'd4, imem_addr);
        $display("test %s done, %0d error(s)", tname[0], terr[0]);
        for (int t = 1; t < 6; t++) begin
            cur_test = t;
            wait (st_idx >= tend[t]);
            @(negedge clk_1hz);
            $display("test %s done, %0d error(s)", tname[t], terr[t]);
        end
        repeat (4) @(negedge clk_1hz); // Catch any late stray store
        $display("tests 6, stores %0d of %0d, errors %0d", st_idx, n_exp, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_control.sv
source/cpu_imm_gen.sv
source/cpu_regfile.sv
source/cpu_alu.sv
source/cpu_core.sv
tests/tb_cpu.sv

//--- run.sh
#!/bin/sh
# Build the core with its testbench under Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_cpu -o sim_tb_cpu &&
./obj_dir/sim_tb_cpu | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" || { echo "FAIL"; exit 1; }
